// File: hw/fp_defines.svh
/*
 * Width and count macros for the shared normalize and round back end.
 * Single precision only. FP_NUM_UNITS may be 1 to 8.
 * Include this file wherever a macro is needed. The guard keeps
 * repeated inclusion harmless.
 */

`ifndef FP_DEFINES_SVH
`define FP_DEFINES_SVH

// Result word and its fields
`define FP_FLEN 32
`define FP_EXPO_WIDTH 8
`define FP_FRAC_WIDTH 23

// Guard, round and sticky below the fraction
`define FP_GRS_WIDTH 3

// Feeding units and writeback ids
`define FP_NUM_UNITS 3
`define FP_ID_WIDTH 3

`endif

// File: hw/fp_format_pkg.sv
/*
 * Types of the single-precision number format and the rounding modes.
 * The shift amount is wide enough for any leading-zero count over
 * hidden bit, fraction and guard bits.
 */

`include "fp_defines.svh"

package fp_format_pkg;

    // Sign, exponent, fraction
    typedef logic [`FP_FLEN-1:0] fp_word_t;
    typedef logic [`FP_EXPO_WIDTH-1:0] fp_expo_t;
    typedef logic [`FP_FRAC_WIDTH-1:0] fp_frac_t;

    // Guard, round, sticky from high to low
    typedef logic [`FP_GRS_WIDTH-1:0] grs_t;

    // Leading-zero count from the unit
    typedef logic [$clog2(`FP_FRAC_WIDTH + 2)-1:0] fp_shift_amt_t;

    // RISC-V rounding mode encoding
    typedef enum logic [2:0] {
        RNE = 3'd0,
        RTZ = 3'd1,
        RDN = 3'd2,
        RUP = 3'd3,
        RMM = 3'd4
    } fp_rm_t;

endpackage

// File: hw/fp_wb_pkg.sv
/*
 * Types of the writeback side: instruction ids, exception flags and
 * the unit select of the arbiter. One writeback group only.
 */

`include "fp_defines.svh"

package fp_wb_pkg;

    typedef logic [`FP_ID_WIDTH-1:0] wb_id_t;

    // NV, DZ, OF, UF, NX from high to low
    typedef logic [4:0] fflags_t;
    localparam int FFLAG_NV = 4;
    localparam int FFLAG_OF = 2;
    localparam int FFLAG_UF = 1;
    localparam int FFLAG_NX = 0;

    // At least one bit, even for a single unit
    typedef logic [(`FP_NUM_UNITS > 1 ? $clog2(`FP_NUM_UNITS) : 1)-1:0] unit_sel_t;

endpackage

// File: hw/fp_normalize.sv
/*
 * Normalizes an unrounded single-precision intermediate.
 * A carry shifts right by one place only. Otherwise a clear hidden bit
 * shifts left by clz. The unit must keep clz below the exponent, so no
 * subnormal result comes out of this block. Combinational.
 */

`include "fp_defines.svh"

module fp_normalize (
    input  logic                         sign,
    input  fp_format_pkg::fp_expo_t      expo,
    input  logic                         expo_overflow,
    input  fp_format_pkg::fp_frac_t      frac,
    input  logic                         hidden,
    input  logic                         carry,
    input  fp_format_pkg::grs_t          grs_in,
    input  fp_format_pkg::fp_shift_amt_t clz,
    output logic                         sign_norm,
    output fp_format_pkg::fp_expo_t      expo_norm,
    output logic                         expo_overflow_norm,
    output fp_format_pkg::fp_frac_t      frac_norm,
    output logic                         hidden_norm,
    output fp_format_pkg::grs_t          grs_norm
);
    import fp_format_pkg::*;

    localparam int MANT_WIDTH = 1 + `FP_FRAC_WIDTH + `FP_GRS_WIDTH;

    logic [MANT_WIDTH-1:0] mant;
    logic [MANT_WIDTH-1:0] mant_left;
    fp_expo_t              expo_inc;
    logic                  expo_inc_carry;
    logic                  carry_overflow;

    // Hidden bit, fraction and guard bits as one vector
    assign mant = {hidden, frac, grs_in};
    assign mant_left = mant << clz;

    assign {expo_inc_carry, expo_inc} = {1'b0, expo} + 9'd1;
    // All ones after the increment is already infinity territory
    assign carry_overflow = carry & (expo_inc_carry | (&expo_inc));

    assign sign_norm = sign;
    assign expo_overflow_norm = expo_overflow | carry_overflow;

    always_comb begin
        hidden_norm = hidden;
        frac_norm = frac;
        grs_norm = grs_in;
        expo_norm = expo;
        if (carry) begin
            // Carry becomes the hidden bit and the dropped bit joins sticky
            hidden_norm = 1'b1;
            frac_norm = {hidden, frac[`FP_FRAC_WIDTH-1:1]};
            grs_norm = {frac[0], grs_in[2], grs_in[1] | grs_in[0]};
            expo_norm = expo_inc;
        end else if (!hidden && clz != '0) begin
            hidden_norm = mant_left[MANT_WIDTH-1];
            frac_norm = mant_left[MANT_WIDTH-2 -: `FP_FRAC_WIDTH];
            grs_norm = mant_left[`FP_GRS_WIDTH-1:0];
            expo_norm = expo - fp_expo_t'(clz);
        end
    end

endmodule

// File: hw/fp_round_decide.sv
/*
 * Round-up decision for the five IEEE rounding modes, and the word
 * that replaces the result when the exponent overflows.
 * Reserved mode encodings never round up. Combinational.
 */

`include "fp_defines.svh"

module fp_round_decide (
    input  logic                    sign,
    input  fp_format_pkg::fp_rm_t   rm,
    input  fp_format_pkg::grs_t     grs,
    input  logic                    lsb,
    output logic                    roundup,
    output fp_format_pkg::fp_word_t result_if_overflow
);
    import fp_format_pkg::*;

    logic     guard;
    logic     inexact;
    logic     to_infinity;
    fp_word_t infinity;
    fp_word_t max_finite;

    assign guard = grs[2];
    assign inexact = |grs;

    always_comb begin
        roundup = 1'b0;
        case (rm)
            RNE: roundup = guard & (grs[1] | grs[0] | lsb);
            RTZ: roundup = 1'b0;
            RDN: roundup = sign & inexact;
            RUP: roundup = ~sign & inexact;
            RMM: roundup = guard;
            default: roundup = 1'b0;
        endcase
    end

    // Modes that round away from zero in the overflow direction
    assign to_infinity = (rm == RNE) | (rm == RMM) | ((rm == RUP) & ~sign) |
                         ((rm == RDN) & sign);

    assign infinity = {sign, {`FP_EXPO_WIDTH{1'b1}}, {`FP_FRAC_WIDTH{1'b0}}};
    assign max_finite = {sign, {(`FP_EXPO_WIDTH - 1){1'b1}}, 1'b0, {`FP_FRAC_WIDTH{1'b1}}};

    assign result_if_overflow = to_infinity ? infinity : max_finite;

endmodule

// File: hw/fp_norm_round_top.sv
/*
 * Shared normalize and round back end, two register stages.
 * The lowest-indexed unit with done high wins and sees ack in the same
 * cycle, only while the normalize register can advance. Units hold
 * done and fields until ack is seen at a rising edge. A low out_ack
 * holds both stages. Single precision, no NaN generation.
 */

`include "fp_defines.svh"

module fp_norm_round_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         unit_done [`FP_NUM_UNITS],
    input  fp_wb_pkg::wb_id_t            unit_id [`FP_NUM_UNITS],
    input  logic                         unit_sign [`FP_NUM_UNITS],
    input  fp_format_pkg::fp_expo_t      unit_expo [`FP_NUM_UNITS],
    input  logic                         unit_expo_overflow [`FP_NUM_UNITS],
    input  fp_format_pkg::fp_frac_t      unit_frac [`FP_NUM_UNITS],
    input  fp_format_pkg::grs_t          unit_grs [`FP_NUM_UNITS],
    input  fp_format_pkg::fp_shift_amt_t unit_clz [`FP_NUM_UNITS],
    input  logic                         unit_carry [`FP_NUM_UNITS],
    input  logic                         unit_hidden [`FP_NUM_UNITS],
    input  fp_format_pkg::fp_rm_t        unit_rm [`FP_NUM_UNITS],
    input  fp_wb_pkg::fflags_t           unit_fflags [`FP_NUM_UNITS],
    output logic                         unit_ack [`FP_NUM_UNITS],
    input  logic                         out_ack,
    output logic                         out_done,
    output fp_wb_pkg::wb_id_t            out_id,
    output fp_format_pkg::fp_word_t      out_rd,
    output fp_wb_pkg::fflags_t           out_fflags
);
    import fp_format_pkg::*;
    import fp_wb_pkg::*;

    unit_sel_t unit_sel;
    logic      any_done;
    logic      advance_norm;
    logic      advance_round;

    ////////////////////
    // Arbiter

    always_comb begin
        unit_sel = '0;
        any_done = 1'b0;
        // Walk downwards so the lowest index is the last to win
        for (int i = `FP_NUM_UNITS - 1; i >= 0; i--) begin
            if (unit_done[i]) begin
                unit_sel = unit_sel_t'(i);
                any_done = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `FP_NUM_UNITS; i++) begin
            unit_ack[i] = advance_norm & any_done & (unit_sel == unit_sel_t'(i));
        end
    end

    ////////////////////
    // Normalize stage

    logic          norm_valid;
    wb_id_t        norm_id;
    logic          norm_sign;
    fp_expo_t      norm_expo;
    logic          norm_expo_overflow;
    fp_frac_t      norm_frac;
    grs_t          norm_grs;
    fp_shift_amt_t norm_clz;
    logic          norm_carry;
    logic          norm_hidden;
    fp_rm_t        norm_rm;
    fflags_t       norm_fflags;

    always_ff @(posedge clk) begin
        if (rst) begin
            norm_valid <= 1'b0;
        end else if (advance_norm) begin
            norm_valid <= any_done;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_norm) begin
            norm_id <= unit_id[unit_sel];
            norm_sign <= unit_sign[unit_sel];
            norm_expo <= unit_expo[unit_sel];
            norm_expo_overflow <= unit_expo_overflow[unit_sel];
            norm_frac <= unit_frac[unit_sel];
            norm_grs <= unit_grs[unit_sel];
            norm_clz <= unit_clz[unit_sel];
            norm_carry <= unit_carry[unit_sel];
            norm_hidden <= unit_hidden[unit_sel];
            norm_rm <= unit_rm[unit_sel];
            norm_fflags <= unit_fflags[unit_sel];
        end
    end

    logic     sign_n;
    fp_expo_t expo_n;
    logic     expo_overflow_n;
    fp_frac_t frac_n;
    logic     hidden_n;
    grs_t     grs_n;
    logic     roundup_n;
    fp_word_t overflow_word_n;

    fp_normalize fp_normalize_i (
        .sign               (norm_sign),
        .expo               (norm_expo),
        .expo_overflow      (norm_expo_overflow),
        .frac               (norm_frac),
        .hidden             (norm_hidden),
        .carry              (norm_carry),
        .grs_in             (norm_grs),
        .clz                (norm_clz),
        .sign_norm          (sign_n),
        .expo_norm          (expo_n),
        .expo_overflow_norm (expo_overflow_n),
        .frac_norm          (frac_n),
        .hidden_norm        (hidden_n),
        .grs_norm           (grs_n)
    );

    fp_round_decide fp_round_decide_i (
        .sign               (sign_n),
        .rm                 (norm_rm),
        .grs                (grs_n),
        .lsb                (frac_n[0]),
        .roundup            (roundup_n),
        .result_if_overflow (overflow_word_n)
    );

    ////////////////////
    // Round stage

    logic     rnd_valid;
    wb_id_t   rnd_id;
    fp_word_t rnd_word;
    logic     rnd_hidden;
    logic     rnd_expo_overflow;
    logic     rnd_roundup;
    fp_word_t rnd_overflow_word;
    fflags_t  rnd_fflags;
    logic     rnd_inexact;

    always_ff @(posedge clk) begin
        if (rst) begin
            rnd_valid <= 1'b0;
        end else if (advance_round) begin
            rnd_valid <= norm_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_round) begin
            rnd_id <= norm_id;
            rnd_word <= {sign_n, expo_n, frac_n};
            rnd_hidden <= hidden_n;
            rnd_expo_overflow <= expo_overflow_n;
            rnd_roundup <= roundup_n;
            rnd_overflow_word <= overflow_word_n;
            rnd_fflags <= norm_fflags;
            rnd_inexact <= |grs_n;
        end
    end

    logic [`FP_FRAC_WIDTH+1:0] mant_sum;
    logic                      mant_carry;
    logic                      hidden_out;
    fp_expo_t                  expo_in;
    fp_expo_t                  expo_out;
    fp_frac_t                  frac_out;
    logic                      overflow;
    logic                      underflow;

    assign expo_in = rnd_word[`FP_FLEN-2 -: `FP_EXPO_WIDTH];

    // Round-up added at the fraction lsb, carry lands above hidden
    assign mant_sum = {1'b0, rnd_hidden, rnd_word[`FP_FRAC_WIDTH-1:0]} +
                      (`FP_FRAC_WIDTH + 2)'(rnd_roundup);
    assign mant_carry = mant_sum[`FP_FRAC_WIDTH+1];
    assign hidden_out = mant_carry | mant_sum[`FP_FRAC_WIDTH];
    assign frac_out = mant_carry ? mant_sum[`FP_FRAC_WIDTH:1] : mant_sum[`FP_FRAC_WIDTH-1:0];
    assign expo_out = expo_in + fp_expo_t'(mant_carry);

    assign overflow = rnd_expo_overflow | (mant_carry & (&expo_out));
    assign underflow = ~hidden_out & (|frac_out);

    always_comb begin
        out_fflags = rnd_fflags;
        // Invalid results keep the unit's flags as they are
        if (!rnd_fflags[FFLAG_NV]) begin
            out_fflags[FFLAG_OF] = rnd_fflags[FFLAG_OF] | overflow;
            out_fflags[FFLAG_UF] = rnd_fflags[FFLAG_UF] | underflow;
            out_fflags[FFLAG_NX] = rnd_fflags[FFLAG_NX] | overflow | rnd_inexact;
        end
    end

    assign out_rd = overflow ? rnd_overflow_word : {rnd_word[`FP_FLEN-1], expo_out, frac_out};
    assign out_id = rnd_id;
    assign out_done = rnd_valid;

    ////////////////////
    // Pipeline control

    assign advance_round = out_ack | ~rnd_valid;
    assign advance_norm = advance_round | ~norm_valid;

endmodule

// File: tb/fp_norm_round_checker.sv
/*
 * Watches the DUT ports and compares each result with the
 * expected table by id. Ids must be unique inside one group, and
 * table_clear starts a new group. Also checks that a stalled result
 * stays put until out_ack, and that only the lowest-indexed unit
 * with done high ever sees ack.
 */

`include "fp_defines.svh"

module fp_norm_round_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    unit_done [`FP_NUM_UNITS],
    input  logic                    unit_ack [`FP_NUM_UNITS],
    input  logic                    out_done,
    input  logic                    out_ack,
    input  fp_wb_pkg::wb_id_t       out_id,
    input  fp_format_pkg::fp_word_t out_rd,
    input  fp_wb_pkg::fflags_t      out_fflags,
    input  logic                    exp_valid [1 << `FP_ID_WIDTH],
    input  fp_format_pkg::fp_word_t exp_rd [1 << `FP_ID_WIDTH],
    input  fp_wb_pkg::fflags_t      exp_fflags [1 << `FP_ID_WIDTH],
    input  logic                    table_clear,
    output int                      seen_count,
    output int                      pass_count,
    output int                      fail_count
);
    import fp_format_pkg::*;
    import fp_wb_pkg::*;

    localparam int NUM_IDS = 1 << `FP_ID_WIDTH;
    localparam int NUM_UNITS = `FP_NUM_UNITS;

    logic     seen [NUM_IDS];
    logic     held;
    fp_word_t held_rd;
    wb_id_t   held_id;

    initial begin
        seen_count = 0;
        pass_count = 0;
        fail_count = 0;
        held = 1'b0;
    end

    always @(posedge clk) begin
        logic ok;
        int   first_done;
        if (rst || table_clear) begin
            for (int i = 0; i < NUM_IDS; i++) begin
                seen[i] <= 1'b0;
            end
            seen_count <= 0;
        end else if (out_done && out_ack) begin
            if (!exp_valid[out_id]) begin
                $display("Result with id %0d at time %0t was not expected", out_id, $time);
                fail_count++;
            end else if (seen[out_id]) begin
                $display("Id %0d came out a second time at time %0t", out_id, $time);
                fail_count++;
            end else begin
                ok = 1'b1;
                seen[out_id] <= 1'b1;
                seen_count <= seen_count + 1;
                if (out_rd !== exp_rd[out_id]) begin
                    $display("ERR %0t out_rd id %0d: got %h expected %h",
                             $time, out_id, out_rd, exp_rd[out_id]);
                    ok = 1'b0;
                end
                if (out_fflags !== exp_fflags[out_id]) begin
                    $display("ERR %0t out_fflags id %0d: got %h expected %h",
                             $time, out_id, out_fflags, exp_fflags[out_id]);
                    ok = 1'b0;
                end
                if (ok) begin
                    $display("ok   id %0d rd %h flags %h", out_id, out_rd, out_fflags);
                    pass_count++;
                end else begin
                    fail_count++;
                end
            end
        end

        // Lowest index with done high is the only one allowed an ack
        first_done = NUM_UNITS;
        for (int k = 0; k < NUM_UNITS; k++) begin
            if (unit_done[k] && first_done == NUM_UNITS) begin
                first_done = k;
            end
        end
        for (int k = 0; k < NUM_UNITS; k++) begin
            if (!rst && unit_ack[k] && k != first_done) begin
                $display("ERR %0t unit_ack[%0d]: got 1 expected 0", $time, k);
                fail_count++;
            end
        end

        // A stalled result must not move or vanish
        if (!rst && held) begin
            if (!out_done) begin
                $display("Stalled result with id %0d vanished at time %0t", held_id, $time);
                fail_count++;
            end else if (out_rd !== held_rd) begin
                $display("ERR %0t out_rd under stall: got %h expected %h", $time, out_rd, held_rd);
                fail_count++;
            end
        end
        held <= !rst && out_done && !out_ack;
        held_rd <= out_rd;
        held_id <= out_id;
    end

endmodule

// File: tb/fp_norm_round_tb.sv
/*
 * Testbench for the normalize and round back end. Operations come
 * from tb/fp_norm_round_patterns.txt, one group at a time; a group
 * is raised on its units together and drained before the next one.
 * out_ack drops in random windows.
 */

`include "fp_defines.svh"

module fp_norm_round_tb;
    import fp_format_pkg::*;
    import fp_wb_pkg::*;

    localparam int NU = `FP_NUM_UNITS;
    localparam int NUM_IDS = 1 << `FP_ID_WIDTH;
    localparam int MAX_PAT = 64;
    localparam int TIMEOUT = 200;

    logic clk;
    logic rst;
    logic unit_done [NU];
    wb_id_t unit_id [NU];
    logic unit_sign [NU];
    fp_expo_t unit_expo [NU];
    logic unit_expo_overflow [NU];
    fp_frac_t unit_frac [NU];
    grs_t unit_grs [NU];
    fp_shift_amt_t unit_clz [NU];
    logic unit_carry [NU];
    logic unit_hidden [NU];
    fp_rm_t unit_rm [NU];
    fflags_t unit_fflags [NU];
    logic unit_ack [NU];
    logic out_ack;
    logic out_done;
    wb_id_t out_id;
    fp_word_t out_rd;
    fflags_t out_fflags;

    logic exp_valid [NUM_IDS];
    fp_word_t exp_rd [NUM_IDS];
    fflags_t exp_fflags [NUM_IDS];
    logic table_clear;
    int seen_count;
    int pass_count;
    int fail_count;

    int pat [MAX_PAT][15];
    int num_pat;
    int tb_errors;
    int tb_passes;
    int seed;
    int hold;

    fp_norm_round_top fp_norm_round_top_i (.*);

    fp_norm_round_checker fp_norm_round_checker_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Back-pressure windows of 1 to 4 cycles
    initial begin
        seed = 32'hc2ef;
        hold = 0;
        forever begin
            @(posedge clk);
            if (hold > 0) begin
                out_ack <= 1'b0;
                hold--;
            end else if (($random(seed) & 7) == 0) begin
                hold = $random(seed) & 3;
                out_ack <= 1'b0;
            end else begin
                out_ack <= 1'b1;
            end
        end
    end

    task automatic read_patterns();
        int fd;
        string line;
        num_pat = 0;
        fd = $fopen("tb/fp_norm_round_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the pattern file");
            tb_errors++;
            return;
        end
        while (!$feof(fd) && num_pat < MAX_PAT) begin
            if ($fgets(line, fd) == 0 || line.len() < 2 || line[0] == "#") begin
                continue;
            end
            if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        pat[num_pat][0], pat[num_pat][1], pat[num_pat][2],
                        pat[num_pat][3], pat[num_pat][4], pat[num_pat][5],
                        pat[num_pat][6], pat[num_pat][7], pat[num_pat][8],
                        pat[num_pat][9], pat[num_pat][10], pat[num_pat][11],
                        pat[num_pat][12], pat[num_pat][13], pat[num_pat][14]) == 15) begin
                num_pat++;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_group(input int s, input int e);
        int u;
        int accepted;
        int waited;
        @(posedge clk);
        for (int i = 0; i < NUM_IDS; i++) begin
            exp_valid[i] <= 1'b0;
        end
        for (int i = s; i < e; i++) begin
            exp_valid[pat[i][1]] <= 1'b1;
            exp_rd[pat[i][1]] <= fp_word_t'(pat[i][13]);
            exp_fflags[pat[i][1]] <= fflags_t'(pat[i][14]);
        end
        table_clear <= 1'b1;
        @(posedge clk);
        table_clear <= 1'b0;
        for (int i = s; i < e; i++) begin
            u = pat[i][0];
            unit_id[u] <= wb_id_t'(pat[i][1]);
            unit_sign[u] <= pat[i][2][0];
            unit_expo[u] <= fp_expo_t'(pat[i][3]);
            unit_expo_overflow[u] <= pat[i][4][0];
            unit_frac[u] <= fp_frac_t'(pat[i][5]);
            unit_grs[u] <= grs_t'(pat[i][6]);
            unit_clz[u] <= fp_shift_amt_t'(pat[i][7]);
            unit_carry[u] <= pat[i][8][0];
            unit_hidden[u] <= pat[i][9][0];
            unit_rm[u] <= fp_rm_t'(pat[i][10]);
            unit_fflags[u] <= fflags_t'(pat[i][11]);
            unit_done[u] <= 1'b1;
        end
        accepted = 0;
        waited = 0;
        while (accepted < e - s && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
            for (int k = 0; k < NU; k++) begin
                if (unit_done[k] && unit_ack[k]) begin
                    unit_done[k] <= 1'b0;
                    accepted++;
                end
            end
        end
        if (accepted < e - s) begin
            $display("Timeout: group %0d units were not all acknowledged", pat[s][12]);
            tb_errors++;
            for (int k = 0; k < NU; k++) begin
                unit_done[k] <= 1'b0;
            end
        end
        waited = 0;
        while (seen_count < e - s && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (seen_count < e - s) begin
            $display("Timeout: group %0d, only %0d of %0d results arrived",
                     pat[s][12], seen_count, e - s);
            tb_errors++;
        end
    endtask

    initial begin
        int s;
        int e;
        logic any_ack;
        tb_errors = 0;
        tb_passes = 0;
        rst = 1'b1;
        out_ack = 1'b1;
        table_clear = 1'b0;
        for (int k = 0; k < NU; k++) begin
            unit_done[k] = 1'b0;
            unit_id[k] = '0;
            unit_sign[k] = 1'b0;
            unit_expo[k] = '0;
            unit_expo_overflow[k] = 1'b0;
            unit_frac[k] = '0;
            unit_grs[k] = '0;
            unit_clz[k] = '0;
            unit_carry[k] = 1'b0;
            unit_hidden[k] = 1'b0;
            unit_rm[k] = RNE;
            unit_fflags[k] = '0;
        end
        for (int i = 0; i < NUM_IDS; i++) begin
            exp_valid[i] = 1'b0;
            exp_rd[i] = '0;
            exp_fflags[i] = '0;
        end
        read_patterns();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // Nothing may come out or be acknowledged right after reset
        any_ack = 1'b0;
        for (int k = 0; k < NU; k++) begin
            any_ack = any_ack | unit_ack[k];
        end
        if (out_done !== 1'b0 || any_ack !== 1'b0) begin
            $display("After reset out_done or a unit ack is not low");
            tb_errors++;
        end else begin
            $display("ok   reset state");
            tb_passes++;
        end

        s = 0;
        while (s < num_pat) begin
            e = s;
            while (e < num_pat && pat[e][12] == pat[s][12]) begin
                e++;
            end
            run_group(s, e);
            s = e;
        end

        $display("%0d checks passed, %0d checks failed",
                 pass_count + tb_passes, fail_count + tb_errors);
        if (fail_count + tb_errors == 0 && pass_count == num_pat && num_pat > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+hw
hw/fp_format_pkg.sv
hw/fp_wb_pkg.sv
hw/fp_normalize.sv
hw/fp_round_decide.sv
hw/fp_norm_round_top.sv
tb/fp_norm_round_checker.sv
tb/fp_norm_round_tb.sv

// File: Bender.yml
package:
  name: fp_norm_round

sources:
  - include_dirs:
      - hw
    files:
      - hw/fp_format_pkg.sv
      - hw/fp_wb_pkg.sv
      - hw/fp_normalize.sv
      - hw/fp_round_decide.sv
      - hw/fp_norm_round_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/fp_norm_round_checker.sv
      - tb/fp_norm_round_tb.sv

// File: tb/fp_norm_round_patterns.txt
# unit id sign expo expo_ovf frac grs clz carry hidden rm fflags group | exp_rd exp_fflags
# all hex, one operation per line, ids unique inside a group, one item per unit per group
0 0 0 7f 0 000000 0 00 0 1 0 00 0 3f800000 00
1 1 1 80 0 400000 0 00 0 1 0 00 0 c0400000 00
2 2 0 7f 0 000001 0 00 1 1 1 00 0 40400000 01
2 3 0 82 0 100000 3 03 0 0 0 00 1 3f800003 00
1 4 0 7f 0 000000 4 00 0 1 0 00 1 3f800000 01
0 5 0 7f 0 000001 4 00 0 1 0 00 1 3f800002 01
0 6 0 7f 0 000001 7 00 0 1 1 00 2 3f800001 01
1 7 1 7f 0 000001 1 00 0 1 2 00 2 bf800002 01
2 0 0 7f 0 000001 6 00 0 1 2 00 2 3f800001 01
1 1 0 7f 0 000001 1 00 0 1 3 00 3 3f800002 01
2 2 1 7f 0 000001 7 00 0 1 3 00 3 bf800001 01
0 3 1 7f 0 000000 4 00 0 1 4 00 3 bf800001 01
0 4 0 7f 0 000000 3 00 0 1 4 00 4 3f800000 01
1 5 0 7f 0 7fffff 4 00 0 1 0 00 4 40000000 01
2 6 0 fe 0 7fffff 7 00 0 1 3 00 5 7f800000 05
0 7 1 80 1 000000 0 00 0 1 1 00 5 ff7fffff 05
1 0 0 80 1 000000 0 00 0 1 2 00 5 7f7fffff 05
0 1 1 80 1 000000 0 00 0 1 2 00 6 ff800000 05
1 2 0 00 0 000010 0 00 0 0 0 00 6 00000010 02
2 3 0 7f 0 000000 7 00 0 1 1 10 6 3f800000 10
0 4 0 fe 0 000000 0 00 1 1 0 00 7 7f800000 05
